// File: files.f
+incdir+common
common/mem_pkg.sv
common/icache_pkg.sv
icache/icache_tag_array.sv
icache/icache_data_sram.sv
icache/icache.sv
logic/line_memory.sv
logic/fetch_top.sv
tb/fetch_tb.sv

// File: tb/fetch_trace.txt
# L addr data | F addr hit(1 0 or - for unchecked) | X addr (fetch with flush) | S cycles | I
# addresses and line data in hex, data is word 3 down to word 0
# first fetch misses, other words of the line hit
L 100 13000413130003131300021313000113
F 104 0
F 10c 1
F 100 1
# four lines in set 3, memory lines 03 43 83 c3
L 030 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0
L 430 b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0
L 830 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0
L c30 d3d3d3d3d2d2d2d2d1d1d1d1d0d0d0d0
F 030 0
F 434 0
F 838 0
F c3c 0
F 030 1
F 434 1
F 838 1
F c3c 1
# fifth line in set 3, memory wraps onto line 03
F 1030 0
F 1034 1
# one of the older lines is gone now
F 434 -
F 83c -
# stall with a pending request
L 200 e3e3e3e3e2e2e2e2e1e1e1e1e0e0e0e0
F 200 0
S 3
F 204 1
# flushed miss still fills
L 300 f3f3f3f3f2f2f2f2f1f1f1f1f0f0f0f0
X 300
F 308 1
# stale line until invalidate
L 100 93000413930003139300021393000113
F 104 1
I
F 104 0
F 108 1

// File: tb/fetch_tb.sv
`default_nettype none

`include "icache_macros.svh"

module fetch_tb import icache_pkg::*, mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic rst;
	fetch_req_t req;
	logic downstream_ready;
	logic flush;
	logic invalidate;
	mem_wr_t mem_wr;
	fetch_rsp_t rsp;

	// parsed trace, one entry per operation
	string op_q[$];
	logic [63:0] addr_q[$];
	line_t data_q[$];
	int arg_q[$];
	int lineno_q[$];

	int total_cycles;
	int cycle_limit;
	int cycle_count = 0;
	int errors;
	int checks;
	bit trace_ok;
	logic [31:0] lfsr;

	// reference model: memory plus per-set cached tags and lines
	line_t ref_mem [`MEM_LINES];
	logic ref_valid [`ICACHE_WAYS][`ICACHE_SETS];
	tag_t ref_tag [`ICACHE_WAYS][`ICACHE_SETS];
	line_t ref_line [`ICACHE_WAYS][`ICACHE_SETS];
	int ref_ptr;

	fetch_top fetch_top_inst (
		.clk(clk),
		.rst(rst),
		.req(req),
		.downstream_ready(downstream_ready),
		.flush(flush),
		.invalidate(invalidate),
		.mem_wr(mem_wr),
		.rsp(rsp)
	);

	always #5 clk = ~clk;

	// run limit from the trace length
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the trace did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per address bit
	function automatic logic [63:0] random_addr();
		logic [63:0] a;
		a = '0;
		for (int i = 0; i < 64; i++) begin
			lfsr = lfsr_next(lfsr);
			a = {a[62:0], lfsr[0]};
		end
		return a;
	endfunction

	task automatic check_inst(string name, logic [31:0] exp, logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s inst expected %08h actual %08h", name, exp, act);
		end else begin
			$display("ok %s inst %08h", name, act);
		end
	endtask

	task automatic check_hit(string name, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s hit expected %b actual %b", name, exp, act);
		end else begin
			$display("ok %s hit %b", name, act);
		end
	endtask

	task automatic check_valid(string name, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s valid expected %b actual %b", name, exp, act);
		end else begin
			$display("ok %s valid %b", name, act);
		end
	endtask

	// hit returns the line as cached, miss fills from memory
	task automatic model_fetch(logic [63:0] addr, output logic [31:0] inst);
		index_t idx;
		tag_t tg;
		int way;
		line_t ln;
		idx = addr[9:4];
		tg = addr[63:10];
		way = -1;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (ref_valid[w][idx] && ref_tag[w][idx] == tg) begin
				way = w;
			end
		end
		if (way < 0) begin
			// lowest invalid way, else the rotating pointer
			way = ref_ptr;
			for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
				if (!ref_valid[w][idx]) begin
					way = w;
				end
			end
			ref_valid[way][idx] = 1'b1;
			ref_tag[way][idx] = tg;
			ref_line[way][idx] = ref_mem[addr[11:4]];
			ref_ptr = (ref_ptr + 1) % `ICACHE_WAYS;
		end
		ln = ref_line[way][idx];
		inst = ln[addr[3:2]];
	endtask

	// response checked one cycle after acceptance
	task automatic do_fetch(logic [63:0] addr, bit with_flush, int exp_hit, string name);
		logic [31:0] exp_inst;
		@(posedge clk);
		req.valid <= 1'b1;
		req.addr <= addr;
		flush <= with_flush;
		@(posedge clk);
		req.valid <= 1'b0;
		flush <= 1'b0;
		model_fetch(addr, exp_inst);
		@(negedge clk);
		if (with_flush) begin
			check_valid(name, 1'b0, rsp.valid);
		end else begin
			check_valid(name, 1'b1, rsp.valid);
			check_inst(name, exp_inst, rsp.inst);
			if (exp_hit >= 0) begin
				check_hit(name, logic'(exp_hit == 1), rsp.hit);
			end
		end
	endtask

	// request held with decode stalled, random addresses
	task automatic do_stall(int n, string name);
		@(posedge clk);
		req.valid <= 1'b1;
		req.addr <= random_addr();
		downstream_ready <= 1'b0;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			req.addr <= random_addr();
			@(negedge clk);
			check_valid($sformatf("%s cycle %0d", name, i), 1'b0, rsp.valid);
		end
		@(posedge clk);
		req.valid <= 1'b0;
		downstream_ready <= 1'b1;
	endtask

	task automatic do_load(logic [63:0] addr, line_t data);
		@(posedge clk);
		mem_wr.en <= 1'b1;
		mem_wr.line_addr <= addr;
		mem_wr.data <= data;
		@(posedge clk);
		mem_wr.en <= 1'b0;
		ref_mem[addr[11:4]] = data;
	endtask

	task automatic do_invalidate();
		@(posedge clk);
		invalidate <= 1'b1;
		@(posedge clk);
		invalidate <= 1'b0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				ref_valid[w][s] = 1'b0;
			end
		end
	endtask

	// whole trace parsed up front so the run limit is known
	task automatic read_trace();
		int fd;
		int n;
		int lineno;
		string text;
		string op;
		string hit_tok;
		logic [63:0] addr;
		logic [127:0] data;
		int arg;
		fd = $fopen("tb/fetch_trace.txt", "r");
		trace_ok = (fd != 0);
		lineno = 0;
		while (trace_ok && !$feof(fd)) begin
			text = "";
			n = $fgets(text, fd);
			lineno++;
			if (n == 0 || text.len() < 2 || text[0] == "#") begin
				continue;
			end
			addr = '0;
			data = '0;
			arg = 0;
			n = $sscanf(text, "%s", op);
			if (op == "L") begin
				n = $sscanf(text, "%s %h %h", op, addr, data);
				total_cycles += 2;
			end else if (op == "F") begin
				n = $sscanf(text, "%s %h %s", op, addr, hit_tok);
				arg = (hit_tok == "1") ? 1 : ((hit_tok == "0") ? 0 : -1);
				total_cycles += 2;
			end else if (op == "X") begin
				n = $sscanf(text, "%s %h", op, addr);
				total_cycles += 2;
			end else if (op == "S") begin
				n = $sscanf(text, "%s %d", op, arg);
				total_cycles += arg + 2;
			end else if (op == "I") begin
				total_cycles += 2;
			end else begin
				$display("trace line %0d has an unknown operation", lineno);
				trace_ok = 1'b0;
			end
			op_q.push_back(op);
			addr_q.push_back(addr);
			data_q.push_back(line_t'(data));
			arg_q.push_back(arg);
			lineno_q.push_back(lineno);
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	task automatic run_trace();
		string name;
		for (int i = 0; i < op_q.size(); i++) begin
			name = $sformatf("line %0d %s", lineno_q[i], op_q[i]);
			if (op_q[i] == "L") begin
				do_load(addr_q[i], data_q[i]);
			end else if (op_q[i] == "F") begin
				do_fetch(addr_q[i], 1'b0, arg_q[i], name);
			end else if (op_q[i] == "X") begin
				do_fetch(addr_q[i], 1'b1, -1, name);
			end else if (op_q[i] == "S") begin
				do_stall(arg_q[i], name);
			end else begin
				do_invalidate();
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		req = '0;
		downstream_ready = 1'b1;
		flush = 1'b0;
		invalidate = 1'b0;
		mem_wr = '0;
		lfsr = 32'h4cac6338;
		errors = 0;
		checks = 0;
		total_cycles = 0;
		cycle_limit = 0;
		ref_ptr = 0;
		for (int i = 0; i < `MEM_LINES; i++) begin
			ref_mem[i] = '0;
		end
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			for (int s = 0; s < `ICACHE_SETS; s++) begin
				ref_valid[w][s] = 1'b0;
			end
		end
		read_trace();
		if (!trace_ok) begin
			$display("could not read a valid trace from tb/fetch_trace.txt");
			errors++;
		end else begin
			// reset cycles counted in the limit too
			cycle_limit = 2 * (total_cycles + 4) + 100;
			repeat (4) @(posedge clk);
			rst <= 1'b0;
			run_trace();
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`default_nettype none

`include "icache_macros.svh"

module fetch_top import icache_pkg::*, mem_pkg::*; (
	input logic clk,
	input logic rst,
	input fetch_req_t req,
	input logic downstream_ready,
	input logic flush,
	input logic invalidate,
	input mem_wr_t mem_wr,
	output fetch_rsp_t rsp
);

	// refill path between cache and memory
	logic [`ADDR_W-1:0] mem_addr;
	line_t mem_line;

	icache icache_inst (
		.clk(clk),
		.rst(rst),
		.req(req),
		.downstream_ready(downstream_ready),
		.flush(flush),
		.invalidate(invalidate),
		.mem_addr(mem_addr),
		.mem_line(mem_line),
		.rsp(rsp)
	);

	// write port fed straight from the program loader
	line_memory line_memory_inst (
		.clk(clk),
		.rd_addr(mem_addr),
		.rd_line(mem_line),
		.wr(mem_wr)
	);

endmodule

`default_nettype wire

// File: logic/line_memory.sv
`default_nettype none

`include "icache_macros.svh"

module line_memory import mem_pkg::*; (
	input logic clk,
	input logic [`ADDR_W-1:0] rd_addr,
	output line_t rd_line,
	input mem_wr_t wr
);

	// line index bits, 11 down to 4 for 256 lines
	localparam int IDX_HI = $clog2(`MEM_LINES) + $clog2(`LINE_BYTES) - 1;
	localparam int IDX_LO = $clog2(`LINE_BYTES);

	line_t mem [`MEM_LINES];

	logic [IDX_HI-IDX_LO:0] rd_idx;
	logic [IDX_HI-IDX_LO:0] wr_idx;

	// upper address bits ignored, memory wraps
	assign rd_idx = rd_addr[IDX_HI:IDX_LO];
	assign wr_idx = wr.line_addr[IDX_HI:IDX_LO];

	// empty memory at power up
	initial begin
		for (int i = 0; i < `MEM_LINES; i++) begin
			mem[i] = '0;
		end
	end

	// program load
	// new data readable from the next cycle
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr_idx] <= wr.data;
		end
	end

	// asynchronous read for the refill path
	assign rd_line = mem[rd_idx];

	// program load works on whole lines
	a_wr_aligned: assert property (
		@(posedge clk)
		wr.en |-> (wr.line_addr[IDX_LO-1:0] == '0)
	);

endmodule

`default_nettype wire

// File: icache/icache.sv
`default_nettype none

`include "icache_macros.svh"

module icache import icache_pkg::*, mem_pkg::*; (
	input logic clk,
	input logic rst,
	input fetch_req_t req,
	input logic downstream_ready,
	input logic flush,
	input logic invalidate,
	output logic [`ADDR_W-1:0] mem_addr,
	input line_t mem_line,
	output fetch_rsp_t rsp
);

	// address split
	index_t index;
	tag_t tag;

	// tag array results
	way_mask_t hit_way;
	way_mask_t victim_way;

	// control
	logic accept;
	logic hit;
	logic miss;
	way_mask_t sram_en;

	// sram read data per way
	line_t sram_rdata [`ICACHE_WAYS];

	// response stage registers
	way_mask_t hit_q;
	logic [1:0] offset_q;
	line_t line_q;
	logic rsp_valid_q;

	// line selected for the response
	line_t rsp_line;

	assign index = req.addr[9:4];
	assign tag = req.addr[`ADDR_W-1:10];

	// memory sees the fetch address directly
	// its line comes back in the same cycle
	assign mem_addr = req.addr;

	// no fetch taken while reset is held
	assign accept = !rst && req.valid && downstream_ready;
	assign hit = |hit_way;
	assign miss = accept && !hit;

	// hit reads its own way, miss writes the victim
	always_comb begin
		sram_en = '0;
		if (accept) begin
			sram_en = hit ? hit_way : victim_way;
		end
	end

	icache_tag_array tag_array_inst (
		.clk(clk),
		.rst(rst),
		.index(index),
		.tag(tag),
		.fill(miss),
		.fill_way(victim_way),
		.invalidate(invalidate),
		.hit_way(hit_way),
		.victim_way(victim_way)
	);

	// one sram per way, shared index and write data
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		icache_data_sram data_sram_inst (
			.clk(clk),
			.en(sram_en[w]),
			.we(!hit),
			.index(index),
			.wdata(mem_line),
			.rdata(sram_rdata[w])
		);
	end

	// response valid and hit mask
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid_q <= 1'b0;
			hit_q <= '0;
		end else begin
			// flush kills the response of this cycle's fetch
			rsp_valid_q <= accept && !flush;
			if (accept) begin
				hit_q <= hit_way;
			end
		end
	end

	// payload side of the response stage
	always_ff @(posedge clk) begin
		if (accept) begin
			offset_q <= req.addr[3:2];
			// memory line kept so a miss answers like a hit
			line_q <= mem_line;
		end
	end

	// zero mask means the last fetch missed
	always_comb begin
		rsp_line = line_q;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit_q[w]) begin
				rsp_line = sram_rdata[w];
			end
		end
	end

	always_comb begin
		rsp.valid = rsp_valid_q;
		// word pick from the registered offset
		rsp.inst = rsp_line[offset_q];
		rsp.hit = |hit_q;
	end

	// a valid response always carries a known word
	// an X here means the selected way was never filled
	a_rsp_inst_known: assert property (
		@(posedge clk) disable iff (rst)
		rsp.valid |-> !$isunknown(rsp.inst)
	);

endmodule

`default_nettype wire

// File: icache/icache_data_sram.sv
`default_nettype none

`include "icache_macros.svh"

module icache_data_sram import icache_pkg::*, mem_pkg::*; (
	input logic clk,
	input logic en,
	input logic we,
	input index_t index,
	input line_t wdata,
	output line_t rdata
);

	// line array of one way
	line_t mem [`ICACHE_SETS];

	// single port, write or read per enabled cycle
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				// read data lands one cycle after the enable
				rdata <= mem[index];
			end
		end
	end

	// enable is forced low during reset by the controller
	// so any X here comes from the request path
	a_en_known: assert property (
		@(posedge clk)
		!$isunknown(en)
	);

endmodule

`default_nettype wire

// File: icache/icache_tag_array.sv
`default_nettype none

`include "icache_macros.svh"

module icache_tag_array import icache_pkg::*; (
	input logic clk,
	input logic rst,
	input index_t index,
	input tag_t tag,
	input logic fill,
	input way_mask_t fill_way,
	input logic invalidate,
	output way_mask_t hit_way,
	output way_mask_t victim_way
);

	// tag storage per way and set
	tag_t tags [`ICACHE_WAYS][`ICACHE_SETS];
	// valid bits, one vector of sets per way
	logic [`ICACHE_SETS-1:0] valid [`ICACHE_WAYS];
	// rotating victim pointer, one-hot
	way_mask_t rr_ptr;

	// parallel compare over all ways of the set
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_way[w] = valid[w][index] && (tags[w][index] == tag);
		end
	end

	// lowest invalid way wins
	// full set falls back to the rotating pointer
	always_comb begin
		victim_way = rr_ptr;
		// walk downward so the lowest invalid way is assigned last
		for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid[w][index]) begin
				victim_way = way_mask_t'(1 << w);
			end
		end
	end

	// valid bits and pointer
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid[w] <= '0;
			end
			rr_ptr <= way_mask_t'(1);
		end else if (invalidate) begin
			// invalidate beats any fill in the same cycle
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill_way[w]) begin
					valid[w][index] <= 1'b1;
				end
			end
			// one step per fill
			rr_ptr <= {rr_ptr[`ICACHE_WAYS-2:0], rr_ptr[`ICACHE_WAYS-1]};
		end
	end

	// tag writes, storage only
	always_ff @(posedge clk) begin
		if (fill && !invalidate) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][index] <= tag;
				end
			end
		end
	end

	// a line is never cached twice in one set
	a_hit_onehot0: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0(hit_way)
	);

	// fill must name exactly one way
	a_fill_onehot: assert property (
		@(posedge clk) disable iff (rst)
		fill |-> $onehot(fill_way)
	);

endmodule

`default_nettype wire

// File: common/icache_pkg.sv
`default_nettype none

package icache_pkg;

	`include "icache_macros.svh"

	// set index, address bits 9 down to 4
	typedef logic [$clog2(`ICACHE_SETS)-1:0] index_t;

	// tag, address bits 63 down to 10
	typedef logic [`ADDR_W-$clog2(`ICACHE_SETS)-$clog2(`LINE_BYTES)-1:0] tag_t;

	// one bit per way, one-hot or zero
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	// fetch request from the pc stage
	typedef struct packed {
		logic valid;
		logic [`ADDR_W-1:0] addr;
	} fetch_req_t;

	// fetch response to decode, one cycle after acceptance
	typedef struct packed {
		logic valid;
		logic [31:0] inst;
		// set when the fetch hit in the cache
		logic hit;
	} fetch_rsp_t;

endpackage

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

	`include "icache_macros.svh"

	// one cache line as an array of 32-bit words
	// word k sits at bits 32k+31 down to 32k
	typedef logic [`LINE_BYTES/4-1:0][31:0] line_t;

	// program-load write into the backing memory
	typedef struct packed {
		// write strobe
		logic en;
		// byte address of the line, low four bits ignored
		logic [`ADDR_W-1:0] line_addr;
		// full line to store
		line_t data;
	} mem_wr_t;

endpackage

`default_nettype wire

// File: common/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 64
// bytes per line, four 32-bit words
`define LINE_BYTES 16

// fetch address width
`define ADDR_W 64

// backing memory depth in lines
// 256 lines of 16 bytes, so memory addresses wrap at 4 KiB
`define MEM_LINES 256

`endif
